// File: src/mmuPkg.sv
package mmuPkg;

  // Widths and geometry
  localparam int addrW      = 32;
  localparam int tagW       = 20;    // Page number bits 31:12
  localparam int tableBaseW = 18;    // L1 table is 16 KB aligned
  localparam int numDomains = 16;
  localparam int tlbEntries = 8;

  typedef logic [addrW-1:0]                addrT;
  typedef logic [31:0]                     wordT;
  typedef logic [tagW-1:0]                 vTagT;
  typedef logic [tagW-1:0]                 pTagT;
  typedef logic [3:0]                      domainT;
  typedef logic [1:0]                      apT;
  typedef logic [$clog2(tlbEntries)-1:0]   tlbIdxT;
  typedef logic [tableBaseW-1:0]           tableBaseT;
  typedef logic [2*numDomains-1:0]         accessT;     // Two bits per domain
  typedef logic [7:0]                      fsrT;        // {domain, fault}

  // Descriptor type field, bits 1:0
  localparam logic [1:0] l1Fault   = 2'b00;
  localparam logic [1:0] l1Coarse  = 2'b01;
  localparam logic [1:0] l1Section = 2'b10;
  localparam logic [1:0] l2Small   = 2'b10;

  // Access permission encodings
  localparam apT apNoAccess = 2'b00;
  localparam apT apSupOnly  = 2'b01;
  localparam apT apUserRead = 2'b10;   // User read-only, supervisor full
  localparam apT apFull     = 2'b11;

  // Domain access control
  localparam logic [1:0] daClient  = 2'b01;
  localparam logic [1:0] daManager = 2'b11;

  // Fault status codes
  typedef enum logic [3:0] {
    faultNone       = 4'b0000,
    faultAlign      = 4'b0001,
    faultSecTrans   = 4'b0101,
    faultPageTrans  = 4'b0111,
    faultSecDomain  = 4'b1001,
    faultPageDomain = 4'b1011,
    faultSecPerm    = 4'b1101,
    faultPagePerm   = 4'b1111
  } faultT;

  // Table walker states
  typedef enum logic [1:0] {wsIdle, wsReadL1, wsReadL2, wsDone} walkStateT;

endpackage

// File: src/tlb.sv
`timescale 1ns/1ps

module tlb (
  input  logic           clk,
  input  logic           arstN,
  input  logic           tlbFlush,
  input  mmuPkg::vTagT   lookupTag,
  output logic           hit,
  output mmuPkg::pTagT   hitPtag,
  output mmuPkg::domainT hitDomain,
  output mmuPkg::apT     hitAp,
  output logic           hitSection,
  input  logic           fillEn,
  input  mmuPkg::vTagT   fillTag,
  input  mmuPkg::pTagT   fillPtag,
  input  mmuPkg::domainT fillDomain,
  input  mmuPkg::apT     fillAp,
  input  logic           fillSection
);
  import mmuPkg::*;

  logic   [tlbEntries-1:0] valid;
  vTagT   tagMem     [tlbEntries];
  pTagT   ptagMem    [tlbEntries];
  domainT domainMem  [tlbEntries];
  apT     apMem      [tlbEntries];
  logic   sectionMem [tlbEntries];
  logic   [tlbEntries-1:0] match;
  tlbIdxT hitIdx;
  tlbIdxT rrPtr;                       // Next victim

  // Sections only compare the 1 MB part of the tag
  always_comb begin
    hit    = 1'b0;
    hitIdx = '0;
    for (int i = 0; i < tlbEntries; i++) begin
      match[i] = valid[i] && (sectionMem[i] ? (tagMem[i][19:8] == lookupTag[19:8])
                                            : (tagMem[i] == lookupTag));
      if (match[i] && !hit) begin      // First match wins
        hit    = 1'b1;
        hitIdx = tlbIdxT'(i);
      end
    end
  end

  assign hitPtag    = ptagMem[hitIdx];
  assign hitDomain  = domainMem[hitIdx];
  assign hitAp      = apMem[hitIdx];
  assign hitSection = sectionMem[hitIdx];

  // Valid bits and replacement pointer
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      valid <= '0;
      rrPtr <= '0;
    end else if (tlbFlush) begin
      valid <= '0;                     // Flush beats a fill in the same cycle
    end else if (fillEn) begin
      valid[rrPtr] <= 1'b1;
      rrPtr        <= rrPtr + 1'b1;    // Wraps at tlbEntries
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (fillEn) begin
      tagMem[rrPtr]     <= fillTag;
      ptagMem[rrPtr]    <= fillPtag;
      domainMem[rrPtr]  <= fillDomain;
      apMem[rrPtr]      <= fillAp;
      sectionMem[rrPtr] <= fillSection;
    end
  end

endmodule

// File: src/tableWalker.sv
`timescale 1ns/1ps

module tableWalker (
  input  logic              clk,
  input  logic              arstN,
  input  logic              walkStart,
  input  mmuPkg::addrT      walkAddr,
  input  mmuPkg::tableBaseT tableBase,
  output logic              busReq,
  output mmuPkg::addrT      busAddr,
  input  mmuPkg::wordT      busRdata,
  input  logic              busReady,
  output logic              walkDone,
  output mmuPkg::faultT     walkFault,
  output mmuPkg::domainT    walkDomain,
  output logic              fillEn,
  output mmuPkg::vTagT      fillTag,
  output mmuPkg::pTagT      fillPtag,
  output mmuPkg::domainT    fillDomain,
  output mmuPkg::apT        fillAp,
  output logic              fillSection
);
  import mmuPkg::*;

  walkStateT   state;
  addrT        vaddr;                  // Address being walked
  logic [21:0] l2Base;                 // Coarse table base, bits 31:10
  logic        l1Ready;
  logic        l2Ready;

  assign l1Ready = (state == wsReadL1) && busReady;
  assign l2Ready = (state == wsReadL2) && busReady;

  // Bus request held through stalls
  assign busReq  = (state == wsReadL1) || (state == wsReadL2);
  assign busAddr = (state == wsReadL2) ? {l2Base, vaddr[19:12], 2'b00}
                                       : {tableBase, vaddr[31:20], 2'b00};

  assign walkDone   = (state == wsDone);
  assign fillEn     = walkDone && (walkFault == faultNone);
  assign fillTag    = vaddr[31:12];
  assign walkDomain = fillDomain;      // Reported on translation faults too

  // Control path
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= wsIdle;
      walkFault <= faultNone;
    end else begin
      case (state)
        wsIdle: if (walkStart) state <= wsReadL1;
        wsReadL1:
          if (l1Ready) begin
            case (busRdata[1:0])
              l1Section: begin
                walkFault <= faultNone;
                state     <= wsDone;
              end
              l1Coarse: state <= wsReadL2;
              default: begin           // l1Fault and the unsupported fine type
                walkFault <= faultSecTrans;
                state     <= wsDone;
              end
            endcase
          end
        wsReadL2:
          if (l2Ready) begin
            walkFault <= (busRdata[1:0] == l2Small) ? faultNone : faultPageTrans;
            state     <= wsDone;
          end
        default: state <= wsIdle;      // wsDone lasts one cycle
      endcase
    end
  end

  // Descriptor decode into the translation
  always_ff @(posedge clk) begin
    if (walkStart && (state == wsIdle)) vaddr <= walkAddr;
    if (l1Ready) begin
      fillSection <= (busRdata[1:0] == l1Section);
      l2Base      <= busRdata[31:10];
      fillPtag    <= {busRdata[31:20], 8'h00};       // Low page bits come from VA
      fillAp      <= busRdata[11:10];
      fillDomain  <= (busRdata[1:0] == l1Section || busRdata[1:0] == l1Coarse)
                     ? busRdata[8:5] : '0;           // No domain in a fault entry
    end
    if (l2Ready) begin
      fillPtag <= busRdata[31:12];
      fillAp   <= busRdata[5:4];       // Domain stays from the coarse entry
    end
  end

endmodule

// File: src/faultUnit.sv
`timescale 1ns/1ps

module faultUnit (
  input  logic           clk,
  input  logic           arstN,
  input  logic           checkEn,
  input  mmuPkg::addrT   vaddr,
  input  logic           write,
  input  logic           user,
  input  logic           word,
  input  logic           section,
  input  mmuPkg::domainT domain,
  input  mmuPkg::apT     ap,
  input  mmuPkg::faultT  transFault,
  input  mmuPkg::accessT domainAccess,
  output mmuPkg::faultT  fault,
  output mmuPkg::fsrT    faultStatus,
  output mmuPkg::addrT   faultAddr
);
  import mmuPkg::*;

  logic       alignErr;
  logic [1:0] domBits;                 // Access control of this domain
  logic       apOk;

  assign alignErr = word && (vaddr[1:0] != 2'b00);
  assign domBits  = domainAccess[{domain, 1'b0} +: 2];

  // Permission by AP, only consulted for client domains
  always_comb begin
    case (ap)
      apNoAccess: apOk = 1'b0;
      apSupOnly:  apOk = !user;
      apUserRead: apOk = !(user && write);
      apFull:     apOk = 1'b1;
      default:    apOk = 1'b0;
    endcase
  end

  // Priority order: alignment, translation, domain, permission
  always_comb begin
    if (alignErr) begin
      fault = faultAlign;
    end else if (transFault != faultNone) begin
      fault = transFault;
    end else if (domBits != daClient && domBits != daManager) begin
      fault = section ? faultSecDomain : faultPageDomain;    // 00 and reserved 10
    end else if (domBits == daClient && !apOk) begin
      fault = section ? faultSecPerm : faultPagePerm;
    end else begin
      fault = faultNone;                                     // Manager skips AP
    end
  end

  // FSR and FAR capture on a completed fault
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      faultStatus <= '0;
      faultAddr   <= '0;
    end else if (checkEn && (fault != faultNone)) begin
      faultStatus <= {alignErr ? 4'h0 : domain, fault};     // Domain unknown on align
      faultAddr   <= vaddr;
    end
  end

endmodule

// File: src/mmu.sv
`timescale 1ns/1ps

module mmu (
  input  logic              clk,
  input  logic              arstN,
  input  logic              cpuReq,
  input  mmuPkg::addrT      cpuAddr,
  input  logic              cpuWrite,
  input  logic              cpuUser,
  input  logic              cpuWord,
  output logic              cpuDone,
  output mmuPkg::addrT      cpuPaddr,
  output mmuPkg::faultT     cpuFault,
  output logic              busReq,
  output mmuPkg::addrT      busAddr,
  input  mmuPkg::wordT      busRdata,
  input  logic              busReady,
  input  logic              mmuEnable,
  input  mmuPkg::tableBaseT tableBase,
  input  mmuPkg::accessT    domainAccess,
  input  logic              tlbFlush,
  output mmuPkg::fsrT       faultStatus,
  output mmuPkg::addrT      faultAddr
);
  import mmuPkg::*;

  typedef enum logic [1:0] {ctlIdle, ctlWalk, ctlLookup} ctlStateT;

  ctlStateT ctlState;
  logic     hit;
  pTagT     hitPtag;
  domainT   hitDomain;
  apT       hitAp;
  logic     hitSection;
  logic     fillEn;
  vTagT     fillTag;
  pTagT     fillPtag;
  domainT   fillDomain;
  apT       fillAp;
  logic     fillSection;
  logic     walkStart;
  logic     walkDone;
  faultT    walkFault;
  domainT   walkDomain;
  faultT    transFault;
  faultT    fault;
  domainT   checkDomain;
  accessT   checkAccess;
  logic     lookupNow;                 // Request resolved this cycle if possible
  logic     answerNow;
  logic     walkFail;
  logic     respond;
  addrT     paddr;

  tlb uTlb (.*, .lookupTag(cpuAddr[31:12]));

  tableWalker uWalker (.*, .walkAddr(cpuAddr));

  // Bypass treats every domain as manager so only alignment can fault
  assign checkAccess = mmuEnable ? domainAccess : '1;
  assign transFault  = walkDone ? walkFault : faultNone;
  assign checkDomain = walkDone ? walkDomain : hitDomain;

  faultUnit uFault (
    .clk, .arstN,
    .checkEn(respond), .vaddr(cpuAddr), .write(cpuWrite), .user(cpuUser),
    .word(cpuWord), .section(hitSection), .domain(checkDomain), .ap(hitAp),
    .transFault, .domainAccess(checkAccess), .fault, .faultStatus, .faultAddr
  );

  // New request, or the retry after a fill
  assign lookupNow = ((ctlState == ctlIdle) && cpuReq && !cpuDone) ||
                     (ctlState == ctlLookup);
  assign answerNow = !mmuEnable || hit || (fault == faultAlign);   // Misaligned skips walk
  assign walkStart = lookupNow && !answerNow;
  assign walkFail  = (ctlState == ctlWalk) && walkDone && (walkFault != faultNone);
  assign respond   = (lookupNow && answerNow) || walkFail;

  // Section keeps VA bits 19:12
  assign paddr = !mmuEnable ? cpuAddr
               : {hitPtag[19:8], hitSection ? cpuAddr[19:12] : hitPtag[7:0], cpuAddr[11:0]};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctlState <= ctlIdle;
      cpuDone  <= 1'b0;
      cpuFault <= faultNone;
    end else begin
      cpuDone <= respond;              // One-cycle pulse
      if (respond) cpuFault <= fault;
      case (ctlState)
        ctlWalk:
          if (walkDone) ctlState <= walkFail ? ctlIdle : ctlLookup;   // Fill lands now
        default: ctlState <= walkStart ? ctlWalk : ctlIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (respond) cpuPaddr <= paddr;
  end

endmodule

// File: dv/mmu_chk.sv
`timescale 1ns/1ps

module mmu_chk (
  input logic         clk,
  input logic         arstN,
  input logic         cpuReq,
  input mmuPkg::addrT cpuAddr,
  input logic         cpuWrite,
  input logic         cpuUser,
  input logic         cpuWord,
  input logic         cpuDone,
  input logic         busReq,
  input mmuPkg::addrT busAddr,
  input logic         busReady
);

  int failures = 0;                    // Read back by the testbench

  // Core holds request and fields until the done pulse
  reqStable: assert property (@(posedge clk) disable iff (!arstN)
    cpuReq && !cpuDone |=> cpuReq && $stable(cpuAddr) && $stable(cpuWrite) &&
                           $stable(cpuUser) && $stable(cpuWord))
    else begin
      $error("Core request dropped or changed before cpuDone");
      failures++;
    end

  // Stalled bus read keeps its address
  busHold: assert property (@(posedge clk) disable iff (!arstN)
    busReq && !busReady |=> busReq && $stable(busAddr))
    else begin
      $error("Bus request dropped or moved while busReady was low");
      failures++;
    end

  doneHasReq: assert property (@(posedge clk) disable iff (!arstN)
    $rose(cpuDone) |-> $past(cpuReq))
    else begin
      $error("cpuDone rose with no outstanding request");
      failures++;
    end

endmodule

// File: dv/mmuTb.sv
`timescale 1ns/1ps

module mmuTb;
  import mmuPkg::*;

  localparam int numReqs   = 400;
  localparam int maxCycles = 60;       // Cycle budget per request

  logic      clk;
  logic      arstN;
  logic      cpuReq;
  addrT      cpuAddr;
  logic      cpuWrite;
  logic      cpuUser;
  logic      cpuWord;
  logic      cpuDone;
  addrT      cpuPaddr;
  faultT     cpuFault;
  logic      busReq;
  addrT      busAddr;
  wordT      busRdata;
  logic      busReady;
  logic      mmuEnable;
  tableBaseT tableBase;
  accessT    domainAccess;
  logic      tlbFlush;
  fsrT       faultStatus;
  addrT      faultAddr;

  wordT pageMem [addrT];               // Sparse L1 and L2 tables
  vTagT poolPage [16];                 // Two pages in each of eight MBs
  int   seed     = 72;
  int   busReads = 0;
  int   errors   = 0;
  int   checks   = 0;
  int   reqCount = 0;

  mmu u_dut (.*);

  bind mmu mmu_chk uChk (
    .clk(clk), .arstN(arstN), .cpuReq(cpuReq), .cpuAddr(cpuAddr), .cpuWrite(cpuWrite),
    .cpuUser(cpuUser), .cpuWord(cpuWord), .cpuDone(cpuDone), .busReq(busReq),
    .busAddr(busAddr), .busReady(busReady)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Unwritten words read as fault descriptors that vary with the address
  function automatic wordT readMem(input addrT a);
    if (pageMem.exists(a)) return pageMem[a];
    return {a[31:2] ^ 30'(a[1:0]), 2'b00};
  endfunction

  // Table memory, stalls about a third of the cycles
  always @(posedge clk) begin
    #2;
    busReady <= ($random(seed) % 3) != 0;
    busRdata <= readMem(busAddr);
  end

  always @(negedge clk) begin
    if (busReq && busReady) busReads++;      // Completed descriptor reads
  end

  initial begin
    repeat (numReqs * maxCycles) @(posedge clk);
    $display("Watchdog expired after %0d requests, the DUT stopped answering", reqCount);
    $display("Something failed");
    $finish;
  end

  function automatic logic apAllows(input apT ap, input logic us, input logic wr);
    case (ap)
      2'b00:   return 1'b0;
      2'b01:   return !us;             // Supervisor only
      2'b10:   return !(us && wr);     // User read-only
      default: return 1'b1;
    endcase
  endfunction

  // Reference walk and fault priority
  task automatic modelAccess(input addrT va, input logic wr, us, wd, en,
                             output addrT pa, output faultT f, output domainT dom);
    wordT       l1;
    wordT       l2;
    logic [1:0] da;
    apT         ap;
    logic       sec;
    pa  = va;
    f   = faultNone;
    dom = '0;
    ap  = '0;
    sec = 1'b0;
    l1  = readMem({tableBase, va[31:20], 2'b00});
    l2  = readMem({l1[31:10], va[19:12], 2'b00});
    if (wd && va[1:0] != 2'b00) begin
      f = faultAlign;
    end else if (en) begin
      case (l1[1:0])
        2'b10: begin                   // Section
          sec = 1'b1;
          dom = l1[8:5];
          ap  = l1[11:10];
          pa  = {l1[31:20], va[19:0]};
        end
        2'b01: begin                   // Coarse table, small page
          dom = l1[8:5];
          ap  = l2[5:4];
          pa  = {l2[31:12], va[11:0]};
          if (l2[1:0] != 2'b10) f = faultPageTrans;
        end
        default: f = faultSecTrans;
      endcase
      da = domainAccess[2*int'(dom) +: 2];
      if (f == faultNone) begin
        if (da == 2'b00 || da == 2'b10) f = sec ? faultSecDomain : faultPageDomain;
        else if (da == 2'b01 && !apAllows(ap, us, wr)) f = sec ? faultSecPerm : faultPagePerm;
      end
    end
  endtask

  task automatic buildPool();
    logic [7:0] lo;
    for (int m = 0; m < 8; m++) begin
      lo              = 8'($random(seed));
      poolPage[2*m]   = {12'h200 + 12'(m * 37), lo};
      poolPage[2*m+1] = {12'h200 + 12'(m * 37), lo ^ 8'hA5};
    end
  endtask

  // Entry kinds rotate with each build
  task automatic buildTable(input int build);
    addrT l2Base;
    wordT desc;
    wordT l2;
    pageMem.delete();
    for (int m = 0; m < 8; m++) begin
      l2Base = 32'h0010_0000 + (m << 10);
      desc   = $random(seed);
      case ((m + build) % 4)
        0: desc[1:0] = 2'b00;          // Unmapped MB
        1: desc[1:0] = 2'b10;
        2: begin
          desc[31:10] = l2Base[31:10];
          desc[1:0]   = 2'b01;
          for (int k = 0; k < 2; k++) begin
            l2      = $random(seed);
            l2[1:0] = (2'($random(seed)) == 2'd0) ? 2'b00 : 2'b10;   // Some unmapped
            pageMem[{l2Base[31:10], poolPage[2*m+k][7:0], 2'b00}] = l2;
          end
        end
        default: desc[1:0] = 2'b11;    // Fine table, faults
      endcase
      pageMem[{tableBase, poolPage[2*m][19:8], 2'b00}] = desc;
    end
  endtask

  task automatic flushTlb();
    tlbFlush = 1'b1;
    @(posedge clk);
    #1;
    tlbFlush = 1'b0;
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expV,
                                input logic [31:0] actV);
    errors++;
    $display("** Error %s at %0t: expected 0x%0h, actual 0x%0h", name, $time, expV, actV);
  endtask

  // One request, entered and left 1 ns after a rising edge
  task automatic runRequest(input addrT va, input logic wr, us, wd, en, hitCheck,
                            output logic ok);
    addrT   expPa;
    faultT  expF;
    domainT expDom;
    int     lat;
    int     reads;
    modelAccess(va, wr, us, wd, en, expPa, expF, expDom);
    reads     = busReads;
    lat       = 0;
    mmuEnable = en;
    cpuAddr   = va;
    cpuWrite  = wr;
    cpuUser   = us;
    cpuWord   = wd;
    cpuReq    = 1'b1;
    do begin
      @(negedge clk);
      lat++;
    end while (!cpuDone);
    reads = busReads - reads;
    checks++;
    if (cpuFault !== expF) reportMismatch("fault", 32'(expF), 32'(cpuFault));
    if (expF == faultNone && cpuPaddr !== expPa) reportMismatch("paddr", expPa, cpuPaddr);
    if (expF != faultNone && faultStatus !== {expDom, expF})
      reportMismatch("faultStatus", 32'({expDom, expF}), 32'(faultStatus));
    if (expF != faultNone && faultAddr !== va) reportMismatch("faultAddr", va, faultAddr);
    if (!en && cpuPaddr !== va) reportMismatch("bypassPaddr", va, cpuPaddr);
    if (!en || hitCheck) begin
      if (lat - 1 != 1) reportMismatch(en ? "hitLatency" : "bypassLatency", 1, lat - 1);
      if (reads != 0) reportMismatch(en ? "hitBusReads" : "bypassBusReads", 0, reads);
    end
    ok = (expF == faultNone);
    @(posedge clk);
    #1;
    cpuReq = 1'b0;
    reqCount++;
  endtask

  initial begin
    int   iter;
    addrT va;
    logic wr;
    logic us;
    logic wd;
    logic en;
    logic ok;
    cpuReq       = 1'b0;
    cpuAddr      = '0;
    cpuWrite     = 1'b0;
    cpuUser      = 1'b0;
    cpuWord      = 1'b0;
    busRdata     = '0;
    busReady     = 1'b0;
    mmuEnable    = 1'b1;
    tableBase    = 18'h00010;          // L1 table at 0x40000
    domainAccess = 32'h5555_5555;
    tlbFlush     = 1'b0;
    arstN        = 1'b0;
    buildPool();
    buildTable(0);
    repeat (8) @(posedge clk);
    #1;
    arstN = 1'b1;
    iter  = 0;
    while (reqCount < numReqs) begin
      if (iter % 80 == 0 && iter != 0) begin
        buildTable(iter / 80);         // New table, stale TLB must go
        flushTlb();
      end
      if (iter % 20 == 0) domainAccess = (iter % 40 == 20) ? 32'h5555_5555 : $random(seed);
      va = {poolPage[4'($random(seed))], 12'($random(seed))};
      wr = 1'($random(seed));
      us = 1'($random(seed));
      wd = 1'($random(seed));
      en = 3'($random(seed)) != 3'd0;
      if (wd && 2'($random(seed)) != 2'd0) va[1:0] = 2'b00;   // Mostly aligned
      runRequest(va, wr, us, wd, en, 1'b0, ok);
      if (ok && en && 2'($random(seed)) == 2'd0) runRequest(va, wr, us, wd, en, 1'b1, ok);
      iter++;
    end
    errors += u_dut.uChk.failures;
    $display("Requests: %0d, checks: %0d, errors: %0d", reqCount, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: mmu.f
src/mmuPkg.sv
src/tlb.sv
src/tableWalker.sv
src/faultUnit.sv
src/mmu.sv
dv/mmu_chk.sv
dv/mmuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mmuTb -f mmu.f

# Keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/VmmuTb +verilator+error+limit+1000 || true)
echo "$out"

if grep -qx "Everything OK" <<< "$out"; then
  exit 0
fi
exit 1
